// File: rtl/dds_pkg.sv
package dds_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH    = 8;
    localparam int DATA_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 4;

    // Upper address bits pick the channel
    localparam int CH_IDX_WIDTH  = ADDR_WIDTH - REG_IDX_WIDTH;

    // Sample and waveform table geometry
    localparam int OUT_WIDTH        = 8;
    localparam int TABLE_ADDR_WIDTH = 8;

    // Register indices inside one channel window
    localparam logic [REG_IDX_WIDTH-1:0] REG_CTRL     = REG_IDX_WIDTH'(0);
    localparam logic [REG_IDX_WIDTH-1:0] REG_FREQ     = REG_IDX_WIDTH'(1);
    localparam logic [REG_IDX_WIDTH-1:0] REG_PHASE    = REG_IDX_WIDTH'(2);
    localparam logic [REG_IDX_WIDTH-1:0] REG_TBL_PTR  = REG_IDX_WIDTH'(3);
    localparam logic [REG_IDX_WIDTH-1:0] REG_TBL_DATA = REG_IDX_WIDTH'(4);

    // Waveform select, CTRL bits 2:1
    typedef enum logic [1:0] {
        WAVE_SAW      = 2'd0,
        WAVE_SQUARE   = 2'd1,
        WAVE_TRIANGLE = 2'd2,
        WAVE_TABLE    = 2'd3
    } wave_sel_e;

    // AXI response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

// File: rtl/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if import dds_pkg::*; ();

    // Strobes, one cycle each
    logic                  wr_en;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;

    // Combinational from addr
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;

    modport master (
        output wr_en, rd_en, addr, wdata,
        input  rdata, err
    );

    modport slave (
        input  wr_en, rd_en, addr, wdata,
        output rdata, err
    );

endinterface

// File: rtl/dds_cfg_if.sv
`timescale 1ns/1ps

interface dds_cfg_if import dds_pkg::*; #(
    parameter int PHASE_WIDTH = 32
) ();

    logic                        enable;
    wave_sel_e                   wave_sel;
    logic [PHASE_WIDTH-1:0]      freq;
    logic [PHASE_WIDTH-1:0]      phase;

    // Table write port
    logic                        tbl_we;
    logic [TABLE_ADDR_WIDTH-1:0] tbl_addr;
    logic [OUT_WIDTH-1:0]        tbl_data;

    modport source (
        output enable, wave_sel, freq, phase, tbl_we, tbl_addr, tbl_data
    );

    modport sink (
        input  enable, wave_sel, freq, phase, tbl_we, tbl_addr, tbl_data
    );

endinterface

// File: rtl/axil_slave.sv
`timescale 1ns/1ps

module axil_slave import dds_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Write address
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,

    // Write data
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  wvalid,
    output logic                  wready,

    // Write response
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,

    // Read address
    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,

    // Read data
    output logic [DATA_WIDTH-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,

    reg_bus_if.master             bus
);

    logic      wr_hs;
    logic      rd_hs;
    axi_resp_e resp_code;

    // Address and data are taken together, and only with no response waiting
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;

    // Shared register bus address, so a write in the same cycle wins
    assign rd_hs   = arvalid && !rvalid && !wr_hs;
    assign arready = rd_hs;

    assign bus.wr_en = wr_hs;
    assign bus.rd_en = rd_hs;
    assign bus.addr  = wr_hs ? awaddr : araddr;
    assign bus.wdata = wdata;

    // Register file flags holes in the map
    assign resp_code = bus.err ? RESP_SLVERR : RESP_OKAY;

    // Write response channel
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= resp_code;
        end
    end

    // Read data channel
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Held until rready since rd_hs stays low while rvalid is up
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= bus.rdata;
            rresp <= resp_code;
        end
    end

endmodule

// File: rtl/dds_regfile.sv
`timescale 1ns/1ps

module dds_regfile import dds_pkg::*; #(
    parameter int NUM_CHANNELS = 2,
    parameter int PHASE_WIDTH  = 32
) (
    input  logic      clk,
    input  logic      rst,
    reg_bus_if.slave  bus,
    dds_cfg_if.source cfg [NUM_CHANNELS]
);

    logic [CH_IDX_WIDTH-1:0]     ch_idx;
    logic [REG_IDX_WIDTH-1:0]    reg_idx;
    logic                        mapped;

    // Per-channel state
    logic                        enable_q   [NUM_CHANNELS];
    wave_sel_e                   wave_sel_q [NUM_CHANNELS];
    logic [PHASE_WIDTH-1:0]      freq_q     [NUM_CHANNELS];
    logic [PHASE_WIDTH-1:0]      phase_q    [NUM_CHANNELS];
    logic [TABLE_ADDR_WIDTH-1:0] tbl_ptr_q  [NUM_CHANNELS];

    // Address split
    assign ch_idx  = bus.addr[ADDR_WIDTH-1:REG_IDX_WIDTH];
    assign reg_idx = bus.addr[REG_IDX_WIDTH-1:0];
    assign mapped  = (ch_idx < NUM_CHANNELS) && (reg_idx <= REG_TBL_DATA);
    assign bus.err = !mapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                enable_q[c]   <= 1'b0;
                wave_sel_q[c] <= WAVE_SAW;
                freq_q[c]     <= '0;
                phase_q[c]    <= '0;
                tbl_ptr_q[c]  <= '0;
            end
        end else if (bus.wr_en && mapped) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (ch_idx == c) begin
                    case (reg_idx)
                        REG_CTRL: begin
                            enable_q[c]   <= bus.wdata[0];
                            wave_sel_q[c] <= wave_sel_e'(bus.wdata[2:1]);
                        end
                        REG_FREQ:     freq_q[c]    <= PHASE_WIDTH'(bus.wdata);
                        REG_PHASE:    phase_q[c]   <= PHASE_WIDTH'(bus.wdata);
                        REG_TBL_PTR:  tbl_ptr_q[c] <= bus.wdata[TABLE_ADDR_WIDTH-1:0];
                        // Byte goes out on the table port, pointer steps on
                        REG_TBL_DATA: tbl_ptr_q[c] <= tbl_ptr_q[c] + 1'b1;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Readback mux, zero for holes and for TBL_DATA
    always_comb begin
        bus.rdata = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (mapped && ch_idx == c) begin
                case (reg_idx)
                    REG_CTRL:    bus.rdata = DATA_WIDTH'({wave_sel_q[c], enable_q[c]});
                    REG_FREQ:    bus.rdata = DATA_WIDTH'(freq_q[c]);
                    REG_PHASE:   bus.rdata = DATA_WIDTH'(phase_q[c]);
                    REG_TBL_PTR: bus.rdata = DATA_WIDTH'(tbl_ptr_q[c]);
                    default:     bus.rdata = '0;
                endcase
            end
        end
    end

    // Drive each channel's config port
    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_cfg
        assign cfg[g].enable   = enable_q[g];
        assign cfg[g].wave_sel = wave_sel_q[g];
        assign cfg[g].freq     = freq_q[g];
        assign cfg[g].phase    = phase_q[g];

        // Table written in the handshake cycle at the current pointer
        assign cfg[g].tbl_we   = bus.wr_en && mapped && (ch_idx == g)
                                 && (reg_idx == REG_TBL_DATA);
        assign cfg[g].tbl_addr = tbl_ptr_q[g];
        assign cfg[g].tbl_data = bus.wdata[OUT_WIDTH-1:0];
    end

endmodule

// File: rtl/dds_channel.sv
`timescale 1ns/1ps

module dds_channel import dds_pkg::*; #(
    parameter int PHASE_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    dds_cfg_if.sink              cfg,
    output logic [OUT_WIDTH-1:0] wave_out
);

    localparam int TABLE_DEPTH = 2 ** TABLE_ADDR_WIDTH;
    localparam int P_MSB       = TABLE_ADDR_WIDTH - 1;

    logic [PHASE_WIDTH-1:0]      acc_q;
    logic [PHASE_WIDTH-1:0]      phase_sum;
    logic [TABLE_ADDR_WIDTH-1:0] idx;
    logic [TABLE_ADDR_WIDTH-1:0] idx_q;
    logic [OUT_WIDTH-1:0]        tbl_q;
    logic [OUT_WIDTH-1:0]        shaped;

    logic [OUT_WIDTH-1:0]        table_mem [TABLE_DEPTH];

    // Phase accumulator, parked at zero while disabled
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
        end else if (!cfg.enable) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_q + cfg.freq;
        end
    end

    // Offset applied after the accumulator, top bits index the table
    assign phase_sum = acc_q + cfg.phase;
    assign idx       = phase_sum[PHASE_WIDTH-1 -: TABLE_ADDR_WIDTH];

    // Waveform table, loaded through the register file
    always_ff @(posedge clk) begin
        if (cfg.tbl_we) begin
            table_mem[cfg.tbl_addr] <= cfg.tbl_data;
        end
    end

    // Synchronous table read, index kept alongside for shaping
    always_ff @(posedge clk) begin
        idx_q <= idx;
        tbl_q <= table_mem[idx];
    end

    always_comb begin
        shaped = OUT_WIDTH'(idx_q);
        case (cfg.wave_sel)
            WAVE_SAW: begin
                shaped = OUT_WIDTH'(idx_q);
            end
            WAVE_SQUARE: begin
                shaped = {OUT_WIDTH{idx_q[P_MSB]}};
            end
            // Rising ramp in the lower half, mirrored in the upper half
            WAVE_TRIANGLE: begin
                if (idx_q[P_MSB]) begin
                    shaped = OUT_WIDTH'({~idx_q[P_MSB-1:0], 1'b0});
                end else begin
                    shaped = OUT_WIDTH'({idx_q[P_MSB-1:0], 1'b0});
                end
            end
            WAVE_TABLE: begin
                shaped = tbl_q;
            end
            default: ;
        endcase
    end

    // Output sample register
    always_ff @(posedge clk) begin
        if (rst) begin
            wave_out <= '0;
        end else begin
            wave_out <= shaped;
        end
    end

endmodule

// File: rtl/dds_top.sv
`timescale 1ns/1ps

module dds_top import dds_pkg::*; #(
    parameter int NUM_CHANNELS = 2,
    parameter int PHASE_WIDTH  = 32
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [ADDR_WIDTH-1:0]             awaddr,
    input  logic                              awvalid,
    output logic                              awready,

    input  logic [DATA_WIDTH-1:0]             wdata,
    input  logic                              wvalid,
    output logic                              wready,

    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready,

    input  logic [ADDR_WIDTH-1:0]             araddr,
    input  logic                              arvalid,
    output logic                              arready,

    output logic [DATA_WIDTH-1:0]             rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  logic                              rready,

    // Channel 0 in the low byte
    output logic [NUM_CHANNELS*OUT_WIDTH-1:0] wave_out
);

    reg_bus_if i_bus ();

    dds_cfg_if #(.PHASE_WIDTH(PHASE_WIDTH)) i_cfg [NUM_CHANNELS] ();

    axil_slave i_axil_slave (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bus     (i_bus.master)
    );

    dds_regfile #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .PHASE_WIDTH  (PHASE_WIDTH)
    ) i_dds_regfile (
        .clk (clk),
        .rst (rst),
        .bus (i_bus.slave),
        .cfg (i_cfg)
    );

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_channel
        dds_channel #(
            .PHASE_WIDTH (PHASE_WIDTH)
        ) i_dds_channel (
            .clk      (clk),
            .rst      (rst),
            .cfg      (i_cfg[g]),
            .wave_out (wave_out[g*OUT_WIDTH +: OUT_WIDTH])
        );
    end

endmodule

// File: sim/dds_properties.sv
`timescale 1ns/1ps

module dds_properties import dds_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  awready,
    input logic                  wready,
    input logic                  arready,
    input logic [1:0]            bresp,
    input logic                  bvalid,
    input logic                  bready,
    input logic [DATA_WIDTH-1:0] rdata,
    input logic [1:0]            rresp,
    input logic                  rvalid,
    input logic                  rready
);

    // Read by the testbench at the end of the run
    int unsigned failures = 0;

    // Write response held with the same code until taken
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid && $stable(bresp)
    ) else begin
        $error("bvalid dropped or bresp changed before bready");
        failures++;
    end

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else begin
        $error("rvalid dropped or read data changed before rready");
        failures++;
    end

    // No new transfer while a response waits
    a_no_write_ready: assert property (
        @(posedge clk) disable iff (rst) bvalid |-> !awready && !wready
    ) else begin
        $error("write channel ready while bvalid pending");
        failures++;
    end

    a_no_read_ready: assert property (
        @(posedge clk) disable iff (rst) rvalid |-> !arready
    ) else begin
        $error("arready high while rvalid pending");
        failures++;
    end

    a_reset_idle: assert property (
        @(posedge clk) rst |=> !bvalid && !rvalid
    ) else begin
        $error("response valid in the cycle after reset");
        failures++;
    end

endmodule

bind axil_slave dds_properties i_dds_properties (.*);

// File: sim/tb_dds_top.sv
`timescale 1ns/1ps

module tb_dds_top import dds_pkg::*; ();

    localparam int NUM_CHANNELS = 2;
    // Table load dominates the run at about 1100 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic                              clk = 1'b0;
    logic                              rst;
    logic [ADDR_WIDTH-1:0]             awaddr;
    logic                              awvalid;
    logic                              awready;
    logic [DATA_WIDTH-1:0]             wdata;
    logic                              wvalid;
    logic                              wready;
    logic [1:0]                        bresp;
    logic                              bvalid;
    logic                              bready;
    logic [ADDR_WIDTH-1:0]             araddr;
    logic                              arvalid;
    logic                              arready;
    logic [DATA_WIDTH-1:0]             rdata;
    logic [1:0]                        rresp;
    logic                              rvalid;
    logic                              rready;
    logic [NUM_CHANNELS*OUT_WIDTH-1:0] wave_out;

    int unsigned error_count = 0;
    int unsigned cycle_count = 0;
    int unsigned assert_count;

    // Expected register and table contents
    logic [DATA_WIDTH-1:0] ctrl_exp  [NUM_CHANNELS];
    logic [DATA_WIDTH-1:0] freq_exp  [NUM_CHANNELS];
    logic [DATA_WIDTH-1:0] phase_exp [NUM_CHANNELS];
    logic [OUT_WIDTH-1:0]  table_exp [256];

    dds_top #(.NUM_CHANNELS(NUM_CHANNELS), .PHASE_WIDTH(32)) i_dds_top (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] addr_of(input int ch, input logic [3:0] idx);
        return {4'(ch), idx};
    endfunction

    // Expected sample for table index p
    function automatic logic [7:0] expected_sample(input logic [1:0] sel, input logic [7:0] p);
        case (sel)
            WAVE_SAW:      return p;
            WAVE_SQUARE:   return (p >= 8'd128) ? 8'hff : 8'h00;
            WAVE_TRIANGLE: return (p < 8'd128) ? 8'(2 * p) : 8'(2 * (255 - p));
            default:       return table_exp[p];
        endcase
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input int stall, output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= (stall == 0);
        do @(posedge clk); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // Second write offered while the response is held back
        if (stall > 0) begin
            awaddr  <= addr_of(1, REG_PHASE);
            wdata   <= ~data;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            if (awready || wready) report_error("write accepted while bvalid pending");
            if (!bvalid || bresp !== resp) report_error("write response not held");
        end
        if (stall > 0) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b1;
            @(posedge clk);
        end
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (stall == 0);
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        // Unmapped read offered while rvalid waits
        if (stall > 0) begin
            araddr  <= addr_of(2, REG_CTRL);
            arvalid <= 1'b1;
        end
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            if (arready) report_error("read accepted while rvalid pending");
            if (!rvalid || rdata !== data || rresp !== resp) report_error("read data not held");
        end
        if (stall > 0) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            @(posedge clk);
        end
        rready <= 1'b0;
    endtask

    task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, 0, resp);
        if (resp !== RESP_OKAY) report_error($sformatf("write 0x%02h bresp %0d", addr, resp));
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [1:0]  resp;
        logic [31:0] data;
        axi_read(addr, 0, data, resp);
        if (resp !== RESP_OKAY) report_error($sformatf("read 0x%02h rresp %0d", addr, resp));
        if (data !== exp) report_error($sformatf("read 0x%02h got 0x%08h exp 0x%08h",
                                                 addr, data, exp));
    endtask

    task automatic check_all_regs();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            read_check(addr_of(ch, REG_CTRL), ctrl_exp[ch] & 32'h7);
            read_check(addr_of(ch, REG_FREQ), freq_exp[ch]);
            read_check(addr_of(ch, REG_PHASE), phase_exp[ch]);
        end
    endtask

    task automatic test_readback();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            freq_exp[ch]  = $urandom;
            phase_exp[ch] = $urandom;
            ctrl_exp[ch]  = $urandom;
            write_ok(addr_of(ch, REG_FREQ), freq_exp[ch]);
            write_ok(addr_of(ch, REG_PHASE), phase_exp[ch]);
            write_ok(addr_of(ch, REG_CTRL), ctrl_exp[ch]);
        end
        check_all_regs();
    endtask

    task automatic test_unmapped();
        logic [7:0]  bad_addr [3] = '{8'h20, 8'h07, 8'h17};
        logic [1:0]  resp;
        logic [31:0] data;
        foreach (bad_addr[i]) begin
            axi_write(bad_addr[i], $urandom, 0, resp);
            if (resp !== RESP_SLVERR) report_error($sformatf("write 0x%02h not SLVERR",
                                                             bad_addr[i]));
            axi_read(bad_addr[i], 0, data, resp);
            if (resp !== RESP_SLVERR || data !== '0) begin
                report_error($sformatf("read 0x%02h got 0x%08h resp %0d",
                                       bad_addr[i], data, resp));
            end
        end
        check_all_regs();
    endtask

    // With the channel disabled the table index is the top byte of the phase offset
    task automatic check_static(input int ch, input logic [1:0] sel);
        logic [7:0] got;
        logic [7:0] exp;
        phase_exp[ch] = $urandom;
        ctrl_exp[ch]  = {29'd0, sel, 1'b0};
        write_ok(addr_of(ch, REG_PHASE), phase_exp[ch]);
        write_ok(addr_of(ch, REG_CTRL), ctrl_exp[ch]);
        repeat (4) @(posedge clk);
        got = wave_out[ch*OUT_WIDTH +: OUT_WIDTH];
        exp = expected_sample(sel, phase_exp[ch][31:24]);
        if (got !== exp) report_error($sformatf("ch%0d wave %0d got 0x%02h exp 0x%02h",
                                                ch, sel, got, exp));
    endtask

    task automatic test_static_waves();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            check_static(ch, WAVE_SAW);
            check_static(ch, WAVE_SQUARE);
            check_static(ch, WAVE_TRIANGLE);
        end
    endtask

    task automatic test_table();
        logic [31:0] data;
        write_ok(addr_of(1, REG_TBL_PTR), 32'd0);
        for (int i = 0; i < 256; i++) begin
            data = $urandom;
            table_exp[i] = data[7:0];
            write_ok(addr_of(1, REG_TBL_DATA), data);
            // Pointer steps once per byte written
            if (i == 127) read_check(addr_of(1, REG_TBL_PTR), 32'd128);
        end
        // Pointer wraps back to 0 after a full table
        read_check(addr_of(1, REG_TBL_PTR), 32'd0);
        read_check(addr_of(1, REG_TBL_DATA), 32'd0);
        repeat (8) check_static(1, WAVE_TABLE);
    endtask

    task automatic test_frequency();
        logic [7:0] prev;
        logic [7:0] hold;
        freq_exp[0] = 32'h0100_0000;
        ctrl_exp[0] = 32'h1;
        write_ok(addr_of(0, REG_FREQ), freq_exp[0]);
        write_ok(addr_of(0, REG_CTRL), ctrl_exp[0]);
        repeat (4) @(posedge clk);
        prev = wave_out[7:0];
        hold = wave_out[15:8];
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            if (wave_out[7:0] !== 8'(prev + 1)) begin
                report_error($sformatf("saw step got 0x%02h after 0x%02h", wave_out[7:0], prev));
            end
            if (wave_out[15:8] !== hold) report_error("disabled channel 1 output moved");
            prev = wave_out[7:0];
        end
        ctrl_exp[0] = 32'h0;
        write_ok(addr_of(0, REG_CTRL), ctrl_exp[0]);
    endtask

    task automatic test_back_pressure();
        logic [1:0]  resp;
        logic [31:0] data;
        freq_exp[1] = $urandom;
        axi_write(addr_of(1, REG_FREQ), freq_exp[1], 1 + ($urandom % 10), resp);
        if (resp !== RESP_OKAY) report_error("stalled write not OKAY");
        // Offered second write must not have landed
        read_check(addr_of(1, REG_PHASE), phase_exp[1]);
        axi_read(addr_of(1, REG_FREQ), 1 + ($urandom % 10), data, resp);
        if (resp !== RESP_OKAY || data !== freq_exp[1]) begin
            report_error($sformatf("stalled read got 0x%08h resp %0d", data, resp));
        end
        check_all_regs();
    endtask

    initial begin
        void'($urandom(32'h4734_5eae));
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_readback();
        test_unmapped();
        test_static_waves();
        test_table();
        test_frequency();
        test_back_pressure();
        repeat (2) @(posedge clk);
        assert_count = i_dds_top.i_axil_slave.i_dds_properties.failures;
        $display("errors: %0d, assertion failures: %0d", error_count, assert_count);
        if (error_count == 0 && assert_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: dds_top.f
rtl/dds_pkg.sv
rtl/reg_bus_if.sv
rtl/dds_cfg_if.sv
rtl/axil_slave.sv
rtl/dds_regfile.sv
rtl/dds_channel.sv
rtl/dds_top.sv
sim/dds_properties.sv
sim/tb_dds_top.sv
